//--- mips_pkg.sv
package mips_pkg;

	// datapath and field widths
	localparam int nb_data   = 32;
	localparam int nb_reg    = 5;
	localparam int nb_opcode = 6;
	localparam int nb_funct  = 6;
	localparam int nb_imm    = 16;

	// jal writes the return address here
	localparam logic [nb_reg-1:0] reg_link = 5'd31;

	// primary opcodes, standard mips encoding
	typedef enum logic [nb_opcode-1:0] {
		R_TYPE = 6'h00,
		JAL    = 6'h03,
		BEQ    = 6'h04,
		ADDI   = 6'h08,
		ANDI   = 6'h0c,
		ORI    = 6'h0d,
		LUI    = 6'h0f,
		LB     = 6'h20,
		LW     = 6'h23,
		SB     = 6'h28,
		SW     = 6'h2b
	} opcode_e;

	// r-type function field
	typedef enum logic [nb_funct-1:0] {
		SLL = 6'h00,
		SRL = 6'h02,
		ADD = 6'h20,
		SUB = 6'h22,
		AND = 6'h24,
		OR  = 6'h25,
		XOR = 6'h26,
		SLT = 6'h2a
	} funct_e;

	// operation handed to execute
	typedef enum logic [3:0] {
		ALU_NOP = 4'd0,
		ALU_ADD = 4'd1,
		ALU_SUB = 4'd2,
		ALU_AND = 4'd3,
		ALU_OR  = 4'd4,
		ALU_XOR = 4'd5,
		ALU_SLT = 4'd6,
		ALU_SLL = 4'd7,
		ALU_SRL = 4'd8,
		ALU_LUI = 4'd9
	} alu_op_e;

	// source of the destination register number
	typedef enum logic [1:0] {
		DEST_RT   = 2'd0,
		DEST_RD   = 2'd1,
		DEST_LINK = 2'd2
	} reg_dest_e;

	// load and store access size
	typedef enum logic [1:0] {
		SIZE_WORD = 2'd0,
		SIZE_BYTE = 2'd1
	} mem_size_e;

endpackage

//--- field_decoder.sv
`timescale 1ns/1ns

module field_decoder (
	input  logic [mips_pkg::nb_data-1:0]   instr_i,
	input  logic                           debug_sel_i,
	input  logic [mips_pkg::nb_reg-1:0]    debug_addr_i,
	input  mips_pkg::reg_dest_e            reg_dest_i,
	input  logic                           zero_ext_i,
	output logic [mips_pkg::nb_opcode-1:0] opcode_o,
	output logic [mips_pkg::nb_funct-1:0]  funct_o,
	output logic [mips_pkg::nb_reg-1:0]    rs_o,
	output logic [mips_pkg::nb_reg-1:0]    rt_o,
	output logic [mips_pkg::nb_reg-1:0]    read_addr_a_o,
	output logic [mips_pkg::nb_reg-1:0]    read_addr_b_o,
	output logic [mips_pkg::nb_reg-1:0]    dest_reg_o,
	output logic [mips_pkg::nb_reg-1:0]    shamt_o,
	output logic [mips_pkg::nb_data-1:0]   imm_o
);

	logic [mips_pkg::nb_reg-1:0] rd;
	logic [mips_pkg::nb_imm-1:0] imm_raw;

	// fixed instruction fields
	assign opcode_o = instr_i[31:26];
	assign rs_o     = instr_i[25:21];
	assign rt_o     = instr_i[20:16];
	assign rd       = instr_i[15:11];
	assign shamt_o  = instr_i[10:6];
	assign funct_o  = instr_i[5:0];
	assign imm_raw  = instr_i[15:0];

	// debug port steals read port a
	assign read_addr_a_o = debug_sel_i ? debug_addr_i : rs_o;
	assign read_addr_b_o = rt_o;

	// logical immediates zero extend, the rest sign extend
	assign imm_o = zero_ext_i ?
		{{(mips_pkg::nb_data - mips_pkg::nb_imm){1'b0}}, imm_raw} :
		{{(mips_pkg::nb_data - mips_pkg::nb_imm){imm_raw[mips_pkg::nb_imm-1]}}, imm_raw};

	// destination chosen by control
	always_comb begin
		case (reg_dest_i)
			mips_pkg::DEST_RD:   dest_reg_o = rd;
			mips_pkg::DEST_LINK: dest_reg_o = mips_pkg::reg_link;
			// i-type and unused encoding
			default:             dest_reg_o = rt_o;
		endcase
	end

endmodule

//--- control_unit.sv
`timescale 1ns/1ns

module control_unit (
	input  logic [mips_pkg::nb_opcode-1:0] opcode_i,
	input  logic [mips_pkg::nb_funct-1:0]  funct_i,
	output mips_pkg::alu_op_e              alu_op_o,
	output logic                           alu_src_imm_o,
	output logic                           shift_o,
	output logic                           mem_read_o,
	output logic                           mem_write_o,
	output mips_pkg::mem_size_e            mem_size_o,
	output logic                           branch_o,
	output logic                           jump_o,
	output logic                           wb_reg_write_o,
	output logic                           wb_mem_to_reg_o,
	output mips_pkg::reg_dest_e            reg_dest_o,
	output logic                           zero_ext_o
);

	always_comb begin
		// defaults describe a bubble
		alu_op_o        = mips_pkg::ALU_NOP;
		alu_src_imm_o   = 1'b0;
		shift_o         = 1'b0;
		mem_read_o      = 1'b0;
		mem_write_o     = 1'b0;
		mem_size_o      = mips_pkg::SIZE_WORD;
		branch_o        = 1'b0;
		jump_o          = 1'b0;
		wb_reg_write_o  = 1'b0;
		wb_mem_to_reg_o = 1'b0;
		reg_dest_o      = mips_pkg::DEST_RT;
		zero_ext_o      = 1'b0;

		case (opcode_i)
			mips_pkg::R_TYPE: begin
				reg_dest_o     = mips_pkg::DEST_RD;
				wb_reg_write_o = 1'b1;
				// operation comes from the function field
				case (funct_i)
					mips_pkg::ADD: alu_op_o = mips_pkg::ALU_ADD;
					mips_pkg::SUB: alu_op_o = mips_pkg::ALU_SUB;
					mips_pkg::AND: alu_op_o = mips_pkg::ALU_AND;
					mips_pkg::OR:  alu_op_o = mips_pkg::ALU_OR;
					mips_pkg::XOR: alu_op_o = mips_pkg::ALU_XOR;
					mips_pkg::SLT: alu_op_o = mips_pkg::ALU_SLT;
					mips_pkg::SLL: begin
						alu_op_o = mips_pkg::ALU_SLL;
						shift_o  = 1'b1;
					end
					mips_pkg::SRL: begin
						alu_op_o = mips_pkg::ALU_SRL;
						shift_o  = 1'b1;
					end
					// unknown funct, drop the write
					default: wb_reg_write_o = 1'b0;
				endcase
			end
			mips_pkg::ADDI, mips_pkg::ANDI, mips_pkg::ORI, mips_pkg::LUI: begin
				alu_src_imm_o  = 1'b1;
				wb_reg_write_o = 1'b1;
				case (opcode_i)
					mips_pkg::ADDI: alu_op_o = mips_pkg::ALU_ADD;
					mips_pkg::ANDI: alu_op_o = mips_pkg::ALU_AND;
					mips_pkg::ORI:  alu_op_o = mips_pkg::ALU_OR;
					default:        alu_op_o = mips_pkg::ALU_LUI;
				endcase
				// only the logical ops zero extend
				zero_ext_o = (opcode_i == mips_pkg::ANDI) || (opcode_i == mips_pkg::ORI);
			end
			mips_pkg::LW, mips_pkg::LB: begin
				// address is base plus offset
				alu_op_o        = mips_pkg::ALU_ADD;
				alu_src_imm_o   = 1'b1;
				mem_read_o      = 1'b1;
				wb_reg_write_o  = 1'b1;
				wb_mem_to_reg_o = 1'b1;
				if (opcode_i == mips_pkg::LB)
					mem_size_o = mips_pkg::SIZE_BYTE;
			end
			mips_pkg::SW, mips_pkg::SB: begin
				alu_op_o      = mips_pkg::ALU_ADD;
				alu_src_imm_o = 1'b1;
				mem_write_o   = 1'b1;
				if (opcode_i == mips_pkg::SB)
					mem_size_o = mips_pkg::SIZE_BYTE;
			end
			mips_pkg::BEQ: begin
				// compare rs and rt by subtraction
				alu_op_o = mips_pkg::ALU_SUB;
				branch_o = 1'b1;
			end
			mips_pkg::JAL: begin
				// return address supplied by fetch, alu idle
				jump_o         = 1'b1;
				wb_reg_write_o = 1'b1;
				reg_dest_o     = mips_pkg::DEST_LINK;
			end
			default: ;
		endcase
	end

endmodule

//--- register_file.sv
`timescale 1ns/1ns

module register_file (
	input  logic                         clock_i,
	input  logic                         arst_n_i,
	input  logic                         write_en_i,
	input  logic [mips_pkg::nb_reg-1:0]  write_addr_i,
	input  logic [mips_pkg::nb_data-1:0] write_data_i,
	input  logic [mips_pkg::nb_reg-1:0]  read_addr_a_i,
	input  logic [mips_pkg::nb_reg-1:0]  read_addr_b_i,
	output logic [mips_pkg::nb_data-1:0] read_data_a_o,
	output logic [mips_pkg::nb_data-1:0] read_data_b_o
);

	localparam int nb_regs = 2 ** mips_pkg::nb_reg;

	logic [mips_pkg::nb_data-1:0] regs [0:nb_regs-1];
	logic                         write_valid;

	// register zero never takes a write
	assign write_valid = write_en_i && (write_addr_i != '0);

	always_ff @(posedge clock_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			for (int i = 0; i < nb_regs; i++)
				regs[i] <= '0;
		end else if (write_valid) begin
			regs[write_addr_i] <= write_data_i;
		end
	end

	// zero first, then bypass, then storage
	always_comb begin
		if (read_addr_a_i == '0)
			read_data_a_o = '0;
		else if (write_valid && (write_addr_i == read_addr_a_i))
			read_data_a_o = write_data_i;
		else
			read_data_a_o = regs[read_addr_a_i];
	end

	// port b, same ordering
	always_comb begin
		if (read_addr_b_i == '0)
			read_data_b_o = '0;
		else if (write_valid && (write_addr_i == read_addr_b_i))
			read_data_b_o = write_data_i;
		else
			read_data_b_o = regs[read_addr_b_i];
	end

endmodule

//--- id_ex_register.sv
`timescale 1ns/1ns

module id_ex_register (
	input  logic                         clock_i,
	input  logic                         arst_n_i,
	input  logic                         flush_i,
	input  mips_pkg::alu_op_e            alu_op_i,
	input  logic                         alu_src_imm_i,
	input  logic                         shift_i,
	input  logic                         mem_read_i,
	input  logic                         mem_write_i,
	input  mips_pkg::mem_size_e          mem_size_i,
	input  logic                         branch_i,
	input  logic                         jump_i,
	input  logic                         wb_reg_write_i,
	input  logic                         wb_mem_to_reg_i,
	input  logic [mips_pkg::nb_data-1:0] data_a_i,
	input  logic [mips_pkg::nb_data-1:0] data_b_i,
	input  logic [mips_pkg::nb_data-1:0] imm_i,
	input  logic [mips_pkg::nb_reg-1:0]  rs_i,
	input  logic [mips_pkg::nb_reg-1:0]  rt_i,
	input  logic [mips_pkg::nb_reg-1:0]  dest_reg_i,
	input  logic [mips_pkg::nb_reg-1:0]  shamt_i,
	output mips_pkg::alu_op_e            alu_op_o,
	output logic                         alu_src_imm_o,
	output logic                         shift_o,
	output logic                         mem_read_o,
	output logic                         mem_write_o,
	output mips_pkg::mem_size_e          mem_size_o,
	output logic                         branch_o,
	output logic                         jump_o,
	output logic                         wb_reg_write_o,
	output logic                         wb_mem_to_reg_o,
	output logic [mips_pkg::nb_data-1:0] data_a_o,
	output logic [mips_pkg::nb_data-1:0] data_b_o,
	output logic [mips_pkg::nb_data-1:0] imm_o,
	output logic [mips_pkg::nb_reg-1:0]  rs_o,
	output logic [mips_pkg::nb_reg-1:0]  rt_o,
	output logic [mips_pkg::nb_reg-1:0]  dest_reg_o,
	output logic [mips_pkg::nb_reg-1:0]  shamt_o
);

	// control half, flush turns it into a bubble
	always_ff @(posedge clock_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			alu_op_o        <= mips_pkg::ALU_NOP;
			alu_src_imm_o   <= 1'b0;
			shift_o         <= 1'b0;
			mem_read_o      <= 1'b0;
			mem_write_o     <= 1'b0;
			mem_size_o      <= mips_pkg::SIZE_WORD;
			branch_o        <= 1'b0;
			jump_o          <= 1'b0;
			wb_reg_write_o  <= 1'b0;
			wb_mem_to_reg_o <= 1'b0;
		end else begin
			alu_op_o        <= flush_i ? mips_pkg::ALU_NOP : alu_op_i;
			alu_src_imm_o   <= alu_src_imm_i && !flush_i;
			shift_o         <= shift_i && !flush_i;
			mem_read_o      <= mem_read_i && !flush_i;
			mem_write_o     <= mem_write_i && !flush_i;
			mem_size_o      <= flush_i ? mips_pkg::SIZE_WORD : mem_size_i;
			branch_o        <= branch_i && !flush_i;
			jump_o          <= jump_i && !flush_i;
			wb_reg_write_o  <= wb_reg_write_i && !flush_i;
			wb_mem_to_reg_o <= wb_mem_to_reg_i && !flush_i;
		end
	end

	// data half loads every cycle, flush or not
	always_ff @(posedge clock_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			data_a_o   <= '0;
			data_b_o   <= '0;
			imm_o      <= '0;
			rs_o       <= '0;
			rt_o       <= '0;
			dest_reg_o <= '0;
			shamt_o    <= '0;
		end else begin
			data_a_o   <= data_a_i;
			data_b_o   <= data_b_i;
			imm_o      <= imm_i;
			rs_o       <= rs_i;
			rt_o       <= rt_i;
			dest_reg_o <= dest_reg_i;
			shamt_o    <= shamt_i;
		end
	end

endmodule

//--- decode_stage.sv
`timescale 1ns/1ns

module decode_stage (
	input  logic                         clock_i,
	input  logic                         arst_n_i,
	input  logic [mips_pkg::nb_data-1:0] instr_i,
	input  logic                         reg_write_i,
	input  logic [mips_pkg::nb_reg-1:0]  write_reg_i,
	input  logic [mips_pkg::nb_data-1:0] write_data_i,
	input  logic                         debug_sel_i,
	input  logic [mips_pkg::nb_reg-1:0]  debug_addr_i,
	input  logic                         flush_i,
	output mips_pkg::alu_op_e            alu_op_o,
	output logic                         alu_src_imm_o,
	output logic                         shift_o,
	output logic                         mem_read_o,
	output logic                         mem_write_o,
	output mips_pkg::mem_size_e          mem_size_o,
	output logic                         branch_o,
	output logic                         jump_o,
	output logic                         wb_reg_write_o,
	output logic                         wb_mem_to_reg_o,
	output logic [mips_pkg::nb_reg-1:0]  rs_o,
	output logic [mips_pkg::nb_reg-1:0]  rt_o,
	output logic [mips_pkg::nb_reg-1:0]  dest_reg_o,
	output logic [mips_pkg::nb_reg-1:0]  shamt_o,
	output logic [mips_pkg::nb_data-1:0] imm_o,
	output logic [mips_pkg::nb_data-1:0] data_a_o,
	output logic [mips_pkg::nb_data-1:0] data_b_o
);

	// decoder to control and register file
	logic [mips_pkg::nb_opcode-1:0] opcode;
	logic [mips_pkg::nb_funct-1:0]  funct;
	logic [mips_pkg::nb_reg-1:0]    rs;
	logic [mips_pkg::nb_reg-1:0]    rt;
	logic [mips_pkg::nb_reg-1:0]    read_addr_a;
	logic [mips_pkg::nb_reg-1:0]    read_addr_b;
	logic [mips_pkg::nb_reg-1:0]    dest_reg;
	logic [mips_pkg::nb_reg-1:0]    shamt;
	logic [mips_pkg::nb_data-1:0]   imm;
	// control back to decoder
	mips_pkg::reg_dest_e            reg_dest;
	logic                           zero_ext;
	// control into the pipeline register
	mips_pkg::alu_op_e              alu_op;
	mips_pkg::mem_size_e            mem_size;
	logic                           alu_src_imm;
	logic                           shift;
	logic                           mem_read;
	logic                           mem_write;
	logic                           branch;
	logic                           jump;
	logic                           wb_reg_write;
	logic                           wb_mem_to_reg;
	// operands
	logic [mips_pkg::nb_data-1:0]   data_a;
	logic [mips_pkg::nb_data-1:0]   data_b;

	field_decoder i_field_decoder (
		.instr_i       (instr_i),
		.debug_sel_i   (debug_sel_i),
		.debug_addr_i  (debug_addr_i),
		.reg_dest_i    (reg_dest),
		.zero_ext_i    (zero_ext),
		.opcode_o      (opcode),
		.funct_o       (funct),
		.rs_o          (rs),
		.rt_o          (rt),
		.read_addr_a_o (read_addr_a),
		.read_addr_b_o (read_addr_b),
		.dest_reg_o    (dest_reg),
		.shamt_o       (shamt),
		.imm_o         (imm)
	);

	control_unit i_control_unit (
		.opcode_i        (opcode),
		.funct_i         (funct),
		.alu_op_o        (alu_op),
		.alu_src_imm_o   (alu_src_imm),
		.shift_o         (shift),
		.mem_read_o      (mem_read),
		.mem_write_o     (mem_write),
		.mem_size_o      (mem_size),
		.branch_o        (branch),
		.jump_o          (jump),
		.wb_reg_write_o  (wb_reg_write),
		.wb_mem_to_reg_o (wb_mem_to_reg),
		.reg_dest_o      (reg_dest),
		.zero_ext_o      (zero_ext)
	);

	// write port driven straight from write-back
	register_file i_register_file (
		.clock_i       (clock_i),
		.arst_n_i      (arst_n_i),
		.write_en_i    (reg_write_i),
		.write_addr_i  (write_reg_i),
		.write_data_i  (write_data_i),
		.read_addr_a_i (read_addr_a),
		.read_addr_b_i (read_addr_b),
		.read_data_a_o (data_a),
		.read_data_b_o (data_b)
	);

	id_ex_register i_id_ex_register (
		.clock_i         (clock_i),
		.arst_n_i        (arst_n_i),
		.flush_i         (flush_i),
		.alu_op_i        (alu_op),
		.alu_src_imm_i   (alu_src_imm),
		.shift_i         (shift),
		.mem_read_i      (mem_read),
		.mem_write_i     (mem_write),
		.mem_size_i      (mem_size),
		.branch_i        (branch),
		.jump_i          (jump),
		.wb_reg_write_i  (wb_reg_write),
		.wb_mem_to_reg_i (wb_mem_to_reg),
		.data_a_i        (data_a),
		.data_b_i        (data_b),
		.imm_i           (imm),
		.rs_i            (rs),
		.rt_i            (rt),
		.dest_reg_i      (dest_reg),
		.shamt_i         (shamt),
		.alu_op_o        (alu_op_o),
		.alu_src_imm_o   (alu_src_imm_o),
		.shift_o         (shift_o),
		.mem_read_o      (mem_read_o),
		.mem_write_o     (mem_write_o),
		.mem_size_o      (mem_size_o),
		.branch_o        (branch_o),
		.jump_o          (jump_o),
		.wb_reg_write_o  (wb_reg_write_o),
		.wb_mem_to_reg_o (wb_mem_to_reg_o),
		.data_a_o        (data_a_o),
		.data_b_o        (data_b_o),
		.imm_o           (imm_o),
		.rs_o            (rs_o),
		.rt_o            (rt_o),
		.dest_reg_o      (dest_reg_o),
		.shamt_o         (shamt_o)
	);

endmodule

//--- decode_stage_checker.sv
`timescale 1ns/1ns

module decode_stage_checker (
	input logic                         clock_i,
	input logic                         arst_n_i,
	input logic [mips_pkg::nb_data-1:0] instr_i,
	input logic                         debug_sel_i,
	input logic                         flush_i,
	input mips_pkg::alu_op_e            alu_op_o,
	input logic                         mem_read_o,
	input logic                         mem_write_o,
	input logic                         branch_o,
	input logic                         jump_o,
	input logic                         wb_reg_write_o,
	input logic [mips_pkg::nb_data-1:0] data_a_o
);

	// failures seen by any assertion below
	int fail_count = 0;

	// reset has had at least one edge to settle
	assert property (@(posedge clock_i)
		!arst_n_i ##1 !arst_n_i |-> alu_op_o == mips_pkg::ALU_NOP && !mem_read_o &&
			!mem_write_o && !branch_o && !jump_o && !wb_reg_write_o)
		else begin
			$error("control outputs active while reset is held");
			fail_count++;
		end

	// flushed slot carries no side effects
	assert property (@(posedge clock_i) disable iff (!arst_n_i)
		flush_i |=> !mem_read_o && !mem_write_o && !wb_reg_write_o)
		else begin
			$error("memory or register write strobe after flush");
			fail_count++;
		end

	// rs of zero reads register zero
	assert property (@(posedge clock_i) disable iff (!arst_n_i)
		(instr_i[25:21] == '0 && !debug_sel_i) |=> data_a_o == '0)
		else begin
			$error("data_a not zero after read of register zero");
			fail_count++;
		end

endmodule

bind decode_stage decode_stage_checker i_decode_stage_checker (.*);

//--- decode_stage_tb.sv
`timescale 1ns/1ns

module decode_stage_tb;

	localparam int num_rows     = 25;
	localparam int reset_cycles = 8;
	localparam int preload_regs = 31;
	localparam int cycle_limit  = 2 * num_rows + preload_regs + reset_cycles;

	// one table row of stimulus
	typedef struct packed {
		logic [31:0] instr;
		logic        flush;
		logic        dbg_sel;
		logic [4:0]  dbg_addr;
		logic        wr_en;
		logic [4:0]  wr_reg;
		logic [31:0] wr_data;
	} stim_t;

	// flags order: src_imm shift mem_rd mem_wr branch jump wb m2r
	typedef struct packed {
		mips_pkg::alu_op_e   alu;
		logic [7:0]          flags;
		mips_pkg::mem_size_e size;
		mips_pkg::reg_dest_e dest;
		logic                zext;
	} expect_t;

	logic                clock;
	logic                arst_n;
	logic [31:0]         instr;
	logic                reg_write;
	logic [4:0]          write_reg;
	logic [31:0]         write_data;
	logic                debug_sel;
	logic [4:0]          debug_addr;
	logic                flush;
	mips_pkg::alu_op_e   alu_op;
	mips_pkg::mem_size_e mem_size;
	logic                alu_src_imm;
	logic                shift;
	logic                mem_read;
	logic                mem_write;
	logic                branch;
	logic                jump;
	logic                wb_reg_write;
	logic                wb_mem_to_reg;
	logic [4:0]          rs;
	logic [4:0]          rt;
	logic [4:0]          dest_reg;
	logic [4:0]          shamt;
	logic [31:0]         imm;
	logic [31:0]         data_a;
	logic [31:0]         data_b;
	logic [7:0]          flags;

	stim_t       stim_tab [num_rows];
	expect_t     exp_tab [num_rows];
	// reference copy of the register file
	logic [31:0] model [32];
	int          seed;
	int          errors;
	int          checker_errors;
	int          cycles;

	assign flags = {alu_src_imm, shift, mem_read, mem_write, branch, jump,
		wb_reg_write, wb_mem_to_reg};

	decode_stage i_decode_stage (
		.clock_i         (clock),
		.arst_n_i        (arst_n),
		.instr_i         (instr),
		.reg_write_i     (reg_write),
		.write_reg_i     (write_reg),
		.write_data_i    (write_data),
		.debug_sel_i     (debug_sel),
		.debug_addr_i    (debug_addr),
		.flush_i         (flush),
		.alu_op_o        (alu_op),
		.alu_src_imm_o   (alu_src_imm),
		.shift_o         (shift),
		.mem_read_o      (mem_read),
		.mem_write_o     (mem_write),
		.mem_size_o      (mem_size),
		.branch_o        (branch),
		.jump_o          (jump),
		.wb_reg_write_o  (wb_reg_write),
		.wb_mem_to_reg_o (wb_mem_to_reg),
		.rs_o            (rs),
		.rt_o            (rt),
		.dest_reg_o      (dest_reg),
		.shamt_o         (shamt),
		.imm_o           (imm),
		.data_a_o        (data_a),
		.data_b_o        (data_b)
	);

	initial begin
		clock = 1'b0;
		forever #50 clock = ~clock;
	end

	// r-type encoding, opcode zero
	function automatic logic [31:0] r_op(logic [5:0] funct, logic [4:0] rs_f, logic [4:0] rt_f,
		logic [4:0] rd_f, logic [4:0] sh_f);
		return {6'h00, rs_f, rt_f, rd_f, sh_f, funct};
	endfunction

	function automatic logic [31:0] i_op(logic [5:0] op, logic [4:0] rs_f, logic [4:0] rt_f,
		logic [15:0] imm_f);
		return {op, rs_f, rt_f, imm_f};
	endfunction

	task automatic fill_table();
		for (int i = 0; i < num_rows; i++)
			stim_tab[i] = '0;
		stim_tab[0].instr = r_op(mips_pkg::ADD, 5'd1, 5'd2, 5'd3, 5'd0);
		exp_tab[0] = '{mips_pkg::ALU_ADD, 8'b0000_0010, mips_pkg::SIZE_WORD, mips_pkg::DEST_RD, '0};
		stim_tab[1].instr = r_op(mips_pkg::SUB, 5'd4, 5'd5, 5'd6, 5'd0);
		exp_tab[1] = '{mips_pkg::ALU_SUB, 8'b0000_0010, mips_pkg::SIZE_WORD, mips_pkg::DEST_RD, '0};
		stim_tab[2].instr = r_op(mips_pkg::AND, 5'd7, 5'd8, 5'd9, 5'd0);
		exp_tab[2] = '{mips_pkg::ALU_AND, 8'b0000_0010, mips_pkg::SIZE_WORD, mips_pkg::DEST_RD, '0};
		stim_tab[3].instr = r_op(mips_pkg::OR, 5'd10, 5'd11, 5'd12, 5'd0);
		exp_tab[3] = '{mips_pkg::ALU_OR, 8'b0000_0010, mips_pkg::SIZE_WORD, mips_pkg::DEST_RD, '0};
		stim_tab[4].instr = r_op(mips_pkg::XOR, 5'd13, 5'd14, 5'd15, 5'd0);
		exp_tab[4] = '{mips_pkg::ALU_XOR, 8'b0000_0010, mips_pkg::SIZE_WORD, mips_pkg::DEST_RD, '0};
		stim_tab[5].instr = r_op(mips_pkg::SLT, 5'd16, 5'd17, 5'd18, 5'd0);
		exp_tab[5] = '{mips_pkg::ALU_SLT, 8'b0000_0010, mips_pkg::SIZE_WORD, mips_pkg::DEST_RD, '0};
		// shifts take rs zero, amount in shamt
		stim_tab[6].instr = r_op(mips_pkg::SLL, 5'd0, 5'd19, 5'd20, 5'd5);
		exp_tab[6] = '{mips_pkg::ALU_SLL, 8'b0100_0010, mips_pkg::SIZE_WORD, mips_pkg::DEST_RD, '0};
		stim_tab[7].instr = r_op(mips_pkg::SRL, 5'd0, 5'd21, 5'd22, 5'd3);
		exp_tab[7] = '{mips_pkg::ALU_SRL, 8'b0100_0010, mips_pkg::SIZE_WORD, mips_pkg::DEST_RD, '0};
		stim_tab[8].instr = i_op(mips_pkg::ADDI, 5'd23, 5'd24, 16'hfff0);
		exp_tab[8] = '{mips_pkg::ALU_ADD, 8'b1000_0010, mips_pkg::SIZE_WORD, mips_pkg::DEST_RT, '0};
		// logical immediates with top bit set
		stim_tab[9].instr = i_op(mips_pkg::ANDI, 5'd25, 5'd26, 16'h8f0f);
		exp_tab[9] = '{mips_pkg::ALU_AND, 8'b1000_0010, mips_pkg::SIZE_WORD, mips_pkg::DEST_RT, '1};
		stim_tab[10].instr = i_op(mips_pkg::ORI, 5'd27, 5'd28, 16'hf00f);
		exp_tab[10] = '{mips_pkg::ALU_OR, 8'b1000_0010, mips_pkg::SIZE_WORD, mips_pkg::DEST_RT, '1};
		stim_tab[11].instr = i_op(mips_pkg::LUI, 5'd0, 5'd29, 16'h1234);
		exp_tab[11] = '{mips_pkg::ALU_LUI, 8'b1000_0010, mips_pkg::SIZE_WORD, mips_pkg::DEST_RT, '0};
		stim_tab[12].instr = i_op(mips_pkg::LW, 5'd30, 5'd2, 16'h0010);
		exp_tab[12] = '{mips_pkg::ALU_ADD, 8'b1010_0011, mips_pkg::SIZE_WORD, mips_pkg::DEST_RT, '0};
		stim_tab[13].instr = i_op(mips_pkg::LB, 5'd1, 5'd3, 16'h8000);
		exp_tab[13] = '{mips_pkg::ALU_ADD, 8'b1010_0011, mips_pkg::SIZE_BYTE, mips_pkg::DEST_RT, '0};
		stim_tab[14].instr = i_op(mips_pkg::SW, 5'd2, 5'd4, 16'h0004);
		exp_tab[14] = '{mips_pkg::ALU_ADD, 8'b1001_0000, mips_pkg::SIZE_WORD, mips_pkg::DEST_RT, '0};
		stim_tab[15].instr = i_op(mips_pkg::SB, 5'd5, 5'd6, 16'hffff);
		exp_tab[15] = '{mips_pkg::ALU_ADD, 8'b1001_0000, mips_pkg::SIZE_BYTE, mips_pkg::DEST_RT, '0};
		stim_tab[16].instr = i_op(mips_pkg::BEQ, 5'd7, 5'd8, 16'h0003);
		exp_tab[16] = '{mips_pkg::ALU_SUB, 8'b0000_1000, mips_pkg::SIZE_WORD, mips_pkg::DEST_RT, '0};
		stim_tab[17].instr = {mips_pkg::JAL, 26'h2a1_b3c4};
		exp_tab[17] = '{mips_pkg::ALU_NOP, 8'b0000_0110, mips_pkg::SIZE_WORD, mips_pkg::DEST_LINK, '0};
		// unknown opcode, then unknown funct
		stim_tab[18].instr = i_op(6'h3f, 5'd3, 5'd4, 16'h7fff);
		exp_tab[18] = '{mips_pkg::ALU_NOP, 8'b0000_0000, mips_pkg::SIZE_WORD, mips_pkg::DEST_RT, '0};
		stim_tab[19].instr = r_op(6'h3f, 5'd9, 5'd10, 5'd11, 5'd0);
		exp_tab[19] = '{mips_pkg::ALU_NOP, 8'b0000_0000, mips_pkg::SIZE_WORD, mips_pkg::DEST_RD, '0};
		// flushed load, data side still moves
		stim_tab[20].instr = i_op(mips_pkg::LW, 5'd11, 5'd12, 16'h8008);
		stim_tab[20].flush = 1'b1;
		exp_tab[20] = '{mips_pkg::ALU_NOP, 8'b0000_0000, mips_pkg::SIZE_WORD, mips_pkg::DEST_RT, '0};
		stim_tab[21].instr = r_op(mips_pkg::OR, 5'd9, 5'd10, 5'd11, 5'd0);
		stim_tab[21].dbg_sel = 1'b1;
		stim_tab[21].dbg_addr = 5'd17;
		exp_tab[21] = '{mips_pkg::ALU_OR, 8'b0000_0010, mips_pkg::SIZE_WORD, mips_pkg::DEST_RD, '0};
		// same-cycle write of r12 read through bypass
		stim_tab[22].instr = r_op(mips_pkg::ADD, 5'd12, 5'd0, 5'd13, 5'd0);
		stim_tab[22].wr_en = 1'b1;
		stim_tab[22].wr_reg = 5'd12;
		stim_tab[22].wr_data = 32'hdead_beef;
		exp_tab[22] = '{mips_pkg::ALU_ADD, 8'b0000_0010, mips_pkg::SIZE_WORD, mips_pkg::DEST_RD, '0};
		// write attempt on r0 while reading it
		stim_tab[23].instr = r_op(mips_pkg::ADD, 5'd0, 5'd12, 5'd1, 5'd0);
		stim_tab[23].wr_en = 1'b1;
		stim_tab[23].wr_data = 32'hffff_ffff;
		exp_tab[23] = '{mips_pkg::ALU_ADD, 8'b0000_0010, mips_pkg::SIZE_WORD, mips_pkg::DEST_RD, '0};
		stim_tab[24].instr = r_op(mips_pkg::SUB, 5'd0, 5'd0, 5'd2, 5'd0);
		exp_tab[24] = '{mips_pkg::ALU_SUB, 8'b0000_0010, mips_pkg::SIZE_WORD, mips_pkg::DEST_RD, '0};
	endtask

	task automatic mismatch(int idx, string what, logic [31:0] got, logic [31:0] want);
		errors++;
		$display("ERROR %0t ns: row %0d %s is %h, expected %h", $time, idx, what, got, want);
	endtask

	task automatic apply_row(int idx);
		instr      = stim_tab[idx].instr;
		flush      = stim_tab[idx].flush;
		debug_sel  = stim_tab[idx].dbg_sel;
		debug_addr = stim_tab[idx].dbg_addr;
		reg_write  = stim_tab[idx].wr_en;
		write_reg  = stim_tab[idx].wr_reg;
		write_data = stim_tab[idx].wr_data;
		// r0 never changes in the model
		if (stim_tab[idx].wr_en && stim_tab[idx].wr_reg != 5'd0)
			model[stim_tab[idx].wr_reg] = stim_tab[idx].wr_data;
	endtask

	task automatic check_row(int idx);
		stim_t       s;
		expect_t     e;
		logic [4:0]  addr_a;
		logic [4:0]  want_dest;
		logic [31:0] want_imm;
		s = stim_tab[idx];
		e = exp_tab[idx];
		addr_a = s.dbg_sel ? s.dbg_addr : s.instr[25:21];
		case (e.dest)
			mips_pkg::DEST_RD:   want_dest = s.instr[15:11];
			mips_pkg::DEST_LINK: want_dest = 5'd31;
			default:             want_dest = s.instr[20:16];
		endcase
		want_imm = e.zext ? {16'h0000, s.instr[15:0]} : {{16{s.instr[15]}}, s.instr[15:0]};
		assert (alu_op == e.alu)
			else mismatch(idx, "alu_op", 32'(alu_op), 32'(e.alu));
		assert (flags == e.flags)
			else mismatch(idx, "control flags", 32'(flags), 32'(e.flags));
		assert (mem_size == e.size)
			else mismatch(idx, "mem_size", 32'(mem_size), 32'(e.size));
		assert (dest_reg == want_dest)
			else mismatch(idx, "dest_reg", 32'(dest_reg), 32'(want_dest));
		assert (imm == want_imm)
			else mismatch(idx, "imm", imm, want_imm);
		// rs and rt, then shamt, rd sits between them
		assert ({rs, rt, shamt} == {s.instr[25:16], s.instr[10:6]})
			else mismatch(idx, "rs/rt/shamt", 32'({rs, rt, shamt}),
				32'({s.instr[25:16], s.instr[10:6]}));
		assert (data_a == model[addr_a])
			else mismatch(idx, "data_a", data_a, model[addr_a]);
		assert (data_b == model[s.instr[20:16]])
			else mismatch(idx, "data_b", data_b, model[s.instr[20:16]]);
	endtask

	initial begin
		seed       = 32'h97c3_36f2;
		errors     = 0;
		arst_n     = 1'b0;
		instr      = '0;
		reg_write  = 1'b0;
		write_reg  = '0;
		write_data = '0;
		debug_sel  = 1'b0;
		debug_addr = '0;
		flush      = 1'b0;
		model[0]   = '0;
		fill_table();
		repeat (reset_cycles) @(posedge clock);
		@(negedge clock);
		// everything cleared while still in reset
		assert (alu_op == mips_pkg::ALU_NOP && flags == '0)
			else mismatch(0, "control under reset", 32'({alu_op, flags}), 32'd0);
		assert ({mem_size, rs, rt, dest_reg, shamt, imm, data_a, data_b} == '0)
			else mismatch(0, "data under reset", data_a | data_b | imm, 32'd0);
		arst_n = 1'b1;
		// preload r1..r31, one write per cycle
		for (int i = 1; i <= preload_regs; i++) begin
			reg_write  = 1'b1;
			write_reg  = 5'(i);
			write_data = $random(seed);
			model[i]   = write_data;
			@(negedge clock);
		end
		reg_write = 1'b0;
		for (int r = 0; r < num_rows; r++) begin
			apply_row(r);
			@(negedge clock);
			check_row(r);
		end
		checker_errors = i_decode_stage.i_decode_stage_checker.fail_count;
		$display("done: %0d rows checked, %0d errors, %0d assertion failures",
			num_rows, errors, checker_errors);
		if (errors == 0 && checker_errors == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

	// run limit in clock cycles
	initial begin
		cycles = 0;
		while (cycles < cycle_limit) begin
			@(posedge clock);
			cycles++;
		end
		$display("timeout: run did not finish within %0d clock cycles", cycle_limit);
		$display("SIMULATION FAILED");
		$finish;
	end

endmodule

//--- sources.f
mips_pkg.sv
field_decoder.sv
control_unit.sv
register_file.sv
id_ex_register.sv
decode_stage.sv
decode_stage_checker.sv
decode_stage_tb.sv

//--- Bender.yml
package:
  name: decode_stage

sources:
  - mips_pkg.sv
  - field_decoder.sv
  - control_unit.sv
  - register_file.sv
  - id_ex_register.sv
  - decode_stage.sv
  - target: simulation
    files:
      - decode_stage_checker.sv
      - decode_stage_tb.sv
